/* compile.f */
+incdir+logic
logic/sv32_pkg.sv
logic/mmu_ctrl_pkg.sv
logic/pte_check.sv
logic/tlb.sv
logic/ptw.sv
logic/mmu_top.sv
verification/mmu_props.sv
verification/mmu_tb.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := mmu_tb
FILELIST := compile.f
OBJ_DIR  := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with $(TOOL)"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* verification/mmu_tb.sv */
`timescale 1ns/1ps
`include "mmu_config.svh"

module mmu_tb;
    import sv32_pkg::*;
    import mmu_ctrl_pkg::*;

    localparam int CLK_PERIOD    = 10;
    localparam int RESET_CYCLES  = 10;
    localparam int DIRECTED_REQS = 22;
    localparam int RAND_REQS     = 200;
    // Two reads of up to 5 cycles each, plus handshake and check cycles
    localparam int WALK_CYCLES   = 18;
    localparam int LIMIT_CYCLES  = RESET_CYCLES + 2 * (DIRECTED_REQS + RAND_REQS) * WALK_CYCLES;

    localparam logic [31:0] SEED = 32'h241b7b2b;
    localparam logic [`MMU_PPN_W-1:0] SATP_PPN = 22'd1;
    // Word indices of the root table (PPN 1) and the level-2 table (PPN 2)
    localparam logic [11:0] ROOT_IDX = 12'h400;
    localparam logic [11:0] L2_IDX   = 12'h800;

    // PTE flag bits
    localparam logic [7:0] F_V   = 8'h01;
    localparam logic [7:0] F_R   = 8'h02;
    localparam logic [7:0] F_W   = 8'h04;
    localparam logic [7:0] F_X   = 8'h08;
    localparam logic [7:0] F_A   = 8'h40;
    localparam logic [7:0] F_D   = 8'h80;
    localparam logic [7:0] F_ALL = F_V | F_R | F_W | F_X | F_A | F_D;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  req_valid;
    logic                  req_ready;
    logic [`MMU_VALEN-1:0] req_vaddr;
    access_e               req_acc;
    logic [`MMU_PPN_W-1:0] satp_ppn;
    logic                  mxr_en;
    logic                  flush;
    logic                  rsp_valid;
    logic [`MMU_PALEN-1:0] rsp_paddr;
    fault_e                rsp_fault;
    logic [`MMU_PALEN-1:0] apb_paddr;
    logic                  apb_psel;
    logic                  apb_penable;
    logic [31:0]           apb_prdata = 32'h0;
    logic                  apb_pready = 1'b0;
    logic                  apb_pslverr = 1'b0;

    // Page table memory, word index is paddr[13:2]
    logic [31:0]           mem [4096];
    logic [31:0]           stim_rng = SEED;
    logic [31:0]           wait_rng = SEED;
    logic [1:0]            waits_left = 2'd0;
    int                    xfer_count = 0;
    int                    rsp_count = 0;
    logic [`MMU_PALEN-1:0] exp_paddr_q [$];
    fault_e                exp_fault_q [$];

    mmu_top dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid_i   (req_valid),
        .req_ready_o   (req_ready),
        .req_vaddr_i   (req_vaddr),
        .req_acc_i     (req_acc),
        .satp_ppn_i    (satp_ppn),
        .mxr_i         (mxr_en),
        .flush_i       (flush),
        .rsp_valid_o   (rsp_valid),
        .rsp_paddr_o   (rsp_paddr),
        .rsp_fault_o   (rsp_fault),
        .apb_paddr_o   (apb_paddr),
        .apb_psel_o    (apb_psel),
        .apb_penable_o (apb_penable),
        .apb_prdata_i  (apb_prdata),
        .apb_pready_i  (apb_pready),
        .apb_pslverr_i (apb_pslverr)
    );

    bind ptw mmu_props u_props (
        .clk         (clk),
        .rst_n       (rst_n),
        .state_i     (state_q),
        .paddr_i     (apb_paddr_o),
        .psel_i      (apb_psel_o),
        .penable_i   (apb_penable_o),
        .pready_i    (apb_pready_i),
        .rsp_valid_i (rsp_valid_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] make_pte(input logic [21:0] ppn, input logic [7:0] flags);
        return {ppn, 2'b00, flags};
    endfunction

    function automatic logic [31:0] vaddr(input logic [9:0] vpn1, input logic [9:0] vpn0,
                                          input logic [11:0] off);
        return {vpn1, vpn0, off};
    endfunction

    // PPN 3 and anything above 16 KiB answer with PSLVERR
    function automatic logic in_error_region(input logic [`MMU_PALEN-1:0] a);
        return (a[33:14] != 20'd0) || (a[13:12] == 2'd3);
    endfunction

    function automatic logic leaf_allows(input logic [31:0] p, input access_e acc,
                                        input logic mxr);
        logic ok;
        case (acc)
            ACC_FETCH: ok = p[3];
            ACC_LOAD:  ok = p[1] || (p[3] && mxr);
            ACC_STORE: ok = p[2] && p[7];
            default:   ok = 1'b0;
        endcase
        return ok && p[6];
    endfunction

    // Expected translation, walking the memory array by the Sv32 rules
    function automatic void ref_translate(input logic [31:0] va, input access_e acc,
                                          input logic mxr, output logic [`MMU_PALEN-1:0] pa,
                                          output fault_e flt, output int reads);
        logic [`MMU_PALEN-1:0] a;
        logic [31:0]           p;
        pa    = '0;
        flt   = FAULT_NONE;
        reads = 0;
        a     = {SATP_PPN, va[31:22], 2'b00};
        for (int lvl = 1; lvl <= 2; lvl++) begin
            reads++;
            if (in_error_region(a)) begin
                flt = FAULT_ACCESS;
                return;
            end
            p = mem[a[13:2]];
            if (!p[0] || (p[2] && !p[1])) begin
                flt = FAULT_PAGE;
                return;
            end
            if (p[1] || p[3]) begin
                if (!leaf_allows(p, acc, mxr) || (lvl == 1 && p[19:10] != 10'd0)) begin
                    flt = FAULT_PAGE;
                    return;
                end
                pa = (lvl == 1) ? {p[31:20], va[21:0]} : {p[31:10], va[11:0]};
                return;
            end
            if (lvl == 2) begin
                flt = FAULT_PAGE;
                return;
            end
            a = {p[31:10], va[21:12], 2'b00};
        end
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "run stopped at the first error");
    endtask

    // APB slave with 0 to 3 wait states
    always @(posedge clk) begin : apb_slave
        logic [1:0] w;
        if (apb_psel && !apb_penable) begin
            wait_rng = xorshift32(wait_rng);
            w = wait_rng[1:0];
            waits_left <= w;
            if (w == 2'd0) begin
                apb_pready  <= 1'b1;
                apb_prdata  <= mem[apb_paddr[13:2]];
                apb_pslverr <= in_error_region(apb_paddr);
            end
        end else if (apb_psel && apb_penable && !apb_pready) begin
            if (waits_left == 2'd1) begin
                apb_pready  <= 1'b1;
                apb_prdata  <= mem[apb_paddr[13:2]];
                apb_pslverr <= in_error_region(apb_paddr);
            end
            waits_left <= waits_left - 2'd1;
        end else begin
            apb_pready  <= 1'b0;
            apb_pslverr <= 1'b0;
        end
    end

    always @(posedge clk) begin
        if (apb_psel && apb_penable && apb_pready) begin
            xfer_count <= xfer_count + 1;
        end
    end

    // Response checker
    always @(negedge clk) begin : check_rsp
        logic [`MMU_PALEN-1:0] want_pa;
        fault_e                want_flt;
        if (rst_n && rsp_valid) begin
            assert (exp_paddr_q.size() != 0)
                else fail_run("Response arrived with no request outstanding");
            want_pa  = exp_paddr_q.pop_front();
            want_flt = exp_fault_q.pop_front();
            assert (rsp_fault == want_flt)
                else fail_run($sformatf("Mismatch at %0t: fault %s, expected %s",
                                        $time, rsp_fault.name(), want_flt.name()));
            assert (rsp_paddr == want_pa)
                else fail_run($sformatf("Mismatch at %0t: paddr %h, expected %h",
                                        $time, rsp_paddr, want_pa));
            rsp_count <= rsp_count + 1;
        end
    end

    task automatic run_request(input logic [31:0] va, input access_e acc, input logic mxr,
                               output int reads, output int walk_reads);
        logic [`MMU_PALEN-1:0] pa;
        fault_e                flt;
        int                    start_xfers;
        int                    want;
        ref_translate(va, acc, mxr, pa, flt, walk_reads);
        exp_paddr_q.push_back(pa);
        exp_fault_q.push_back(flt);
        start_xfers = xfer_count;
        want        = rsp_count + 1;
        @(posedge clk);
        req_valid <= 1'b1;
        req_vaddr <= va;
        req_acc   <= acc;
        mxr_en    <= mxr;
        @(negedge clk);
        while (!req_ready) @(negedge clk);
        @(posedge clk);
        req_valid <= 1'b0;
        // Walker is busy once the request is taken
        @(negedge clk);
        assert (!req_ready)
            else fail_run("Ready stayed high after a request was accepted");
        while (rsp_count < want) @(posedge clk);
        reads = xfer_count - start_xfers;
    endtask

    task automatic check_reads(input int got, input int want);
        assert (got == want)
            else fail_run($sformatf("Mismatch at %0t: %0d APB reads, expected %0d",
                                    $time, got, want));
    endtask

    task automatic flush_tlb();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    task automatic load_tables();
        // Unused words hold an invalid PTE made from their own index
        for (int i = 0; i < 4096; i++) begin
            mem[12'(i)] = {i[11:0], ~i[11:0], i[7:1], 1'b0};
        end
        mem[ROOT_IDX + 12'd0] = make_pte(22'd2, F_V);
        mem[ROOT_IDX + 12'd1] = make_pte({12'h0ab, 10'd0}, F_ALL);
        mem[ROOT_IDX + 12'd2] = make_pte({12'h0ac, 10'h005}, F_V | F_R | F_A);
        mem[ROOT_IDX + 12'd3] = 32'h0;
        mem[ROOT_IDX + 12'd4] = make_pte(22'd3, F_V);
        mem[L2_IDX + 12'd0]   = make_pte(22'h12345, F_ALL);
        mem[L2_IDX + 12'd1]   = make_pte(22'h01111, F_V | F_R | F_A);
        mem[L2_IDX + 12'd2]   = make_pte(22'h02222, F_V | F_R | F_W | F_A);
        mem[L2_IDX + 12'd3]   = make_pte(22'h03333, F_V | F_X | F_A);
        mem[L2_IDX + 12'd4]   = make_pte(22'h04444, F_V | F_R | F_W | F_X | F_D);
        mem[L2_IDX + 12'd5]   = make_pte(22'h05555, F_R | F_W | F_A);
        mem[L2_IDX + 12'd6]   = make_pte(22'd2, F_V);
        mem[L2_IDX + 12'd7]   = make_pte(22'h07777, F_V | F_W | F_A);
    endtask

    // Random pointers, leaves and junk for the first 16 entries of both tables
    task automatic randomize_tables();
        logic [31:0] r;
        logic [7:0]  flags;
        for (int i = 0; i < 16; i++) begin
            stim_rng = xorshift32(stim_rng);
            r        = stim_rng;
            flags    = r[10:3] | {7'd0, r[11] | r[12]};
            case (r[1:0])
                2'd0:    mem[ROOT_IDX + 12'(i)] = make_pte(22'd2, F_V);
                2'd1:    mem[ROOT_IDX + 12'(i)] = make_pte(22'd3, F_V);
                default: mem[ROOT_IDX + 12'(i)] =
                    make_pte({r[31:20], r[13] ? 10'd0 : r[29:20]}, flags);
            endcase
            stim_rng = xorshift32(stim_rng);
            r        = stim_rng;
            flags    = r[7:0] | {7'd0, r[8] | r[9]};
            mem[L2_IDX + 12'(i)] = make_pte(r[31:10], flags);
        end
    endtask

    initial begin : stimulus
        int          reads;
        int          walk;
        logic [31:0] r;
        logic [31:0] va;
        access_e     acc;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_vaddr = '0;
        req_acc   = ACC_LOAD;
        satp_ppn  = SATP_PPN;
        mxr_en    = 1'b0;
        flush     = 1'b0;
        load_tables();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // Two-level walks to a 4 KiB page, TLB empty after reset
        run_request(vaddr(10'd0, 10'd0, 12'h123), ACC_FETCH, 1'b0, reads, walk);
        check_reads(reads, walk);
        flush_tlb();
        run_request(vaddr(10'd0, 10'd0, 12'h456), ACC_LOAD, 1'b0, reads, walk);
        check_reads(reads, walk);
        flush_tlb();
        run_request(vaddr(10'd0, 10'd0, 12'hffc), ACC_STORE, 1'b0, reads, walk);
        check_reads(reads, walk);

        // Megapage, aligned and misaligned
        run_request(vaddr(10'd1, 10'h2a5, 12'h0f0), ACC_LOAD, 1'b0, reads, walk);
        run_request(vaddr(10'd2, 10'd3, 12'h010), ACC_LOAD, 1'b0, reads, walk);

        // Permission and format faults next to passing accesses
        run_request(vaddr(10'd0, 10'd1, 12'h020), ACC_FETCH, 1'b0, reads, walk);
        run_request(vaddr(10'd0, 10'd1, 12'h024), ACC_LOAD, 1'b0, reads, walk);
        run_request(vaddr(10'd0, 10'd1, 12'h028), ACC_STORE, 1'b0, reads, walk);
        run_request(vaddr(10'd0, 10'd2, 12'h02c), ACC_STORE, 1'b0, reads, walk);
        run_request(vaddr(10'd0, 10'd3, 12'h030), ACC_LOAD, 1'b0, reads, walk);
        run_request(vaddr(10'd0, 10'd3, 12'h034), ACC_LOAD, 1'b1, reads, walk);
        run_request(vaddr(10'd0, 10'd4, 12'h038), ACC_LOAD, 1'b0, reads, walk);
        run_request(vaddr(10'd3, 10'd0, 12'h03c), ACC_LOAD, 1'b0, reads, walk);
        run_request(vaddr(10'd0, 10'd5, 12'h040), ACC_LOAD, 1'b0, reads, walk);
        run_request(vaddr(10'd0, 10'd6, 12'h044), ACC_LOAD, 1'b0, reads, walk);
        run_request(vaddr(10'd0, 10'd7, 12'h048), ACC_LOAD, 1'b0, reads, walk);

        // TLB hits need no APB reads, a flush forces a new walk
        flush_tlb();
        run_request(vaddr(10'd0, 10'd0, 12'h040), ACC_LOAD, 1'b0, reads, walk);
        check_reads(reads, walk);
        run_request(vaddr(10'd0, 10'd0, 12'h040), ACC_LOAD, 1'b0, reads, walk);
        check_reads(reads, 0);
        run_request(vaddr(10'd1, 10'd9, 12'h004), ACC_STORE, 1'b0, reads, walk);
        check_reads(reads, walk);
        run_request(vaddr(10'd1, 10'd200, 12'h008), ACC_FETCH, 1'b0, reads, walk);
        check_reads(reads, 0);
        flush_tlb();
        run_request(vaddr(10'd0, 10'd0, 12'h040), ACC_LOAD, 1'b0, reads, walk);
        check_reads(reads, walk);

        // Level-2 table in the error region
        run_request(vaddr(10'd4, 10'd1, 12'h100), ACC_LOAD, 1'b0, reads, walk);

        // Random mix against a randomized table
        randomize_tables();
        flush_tlb();
        for (int i = 0; i < RAND_REQS; i++) begin
            stim_rng = xorshift32(stim_rng);
            r        = stim_rng;
            va       = {6'd0, r[3:0], 6'd0, r[7:4], r[19:8]};
            acc      = (r[21:20] == 2'd3) ? ACC_LOAD : access_e'(r[21:20]);
            run_request(va, acc, r[22], reads, walk);
        end

        repeat (4) @(posedge clk);
        if (exp_paddr_q.size() == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            fail_run("Some requests never got a response");
        end
    end

    initial begin : watchdog
        #(LIMIT_CYCLES * CLK_PERIOD);
        fail_run("Timeout: the run did not finish in the allowed time");
    end

endmodule

/* verification/mmu_props.sv */
`timescale 1ns/1ps
`include "mmu_config.svh"

module mmu_props (
    input logic                     clk,
    input logic                     rst_n,
    input mmu_ctrl_pkg::ptw_state_e state_i,
    input logic [`MMU_PALEN-1:0]    paddr_i,
    input logic                     psel_i,
    input logic                     penable_i,
    input logic                     pready_i,
    input logic                     rsp_valid_i
);
    import mmu_ctrl_pkg::*;

    // Address held from the setup phase until the transfer completes
    addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        psel_i && !(penable_i && pready_i) |=> $stable(paddr_i))
        else $error("APB address changed while a transfer was pending");

    // Access phase only follows a setup cycle
    enable_after_setup: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(penable_i) |-> $past(psel_i && !penable_i))
        else $error("APB penable rose without a setup cycle");

    rsp_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid_i |=> !rsp_valid_i)
        else $error("Response valid held for more than one cycle");

    idle_bus_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (state_i == PTW_IDLE) |-> (!psel_i && !penable_i))
        else $error("APB activity while the walker is idle");

endmodule

/* logic/mmu_top.sv */
`timescale 1ns/1ps
`include "mmu_config.svh"

module mmu_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    input  logic [`MMU_VALEN-1:0] req_vaddr_i,
    input  sv32_pkg::access_e     req_acc_i,
    input  logic [`MMU_PPN_W-1:0] satp_ppn_i,
    input  logic                  mxr_i,
    input  logic                  flush_i,
    output logic                  rsp_valid_o,
    output logic [`MMU_PALEN-1:0] rsp_paddr_o,
    output mmu_ctrl_pkg::fault_e  rsp_fault_o,
    output logic [`MMU_PALEN-1:0] apb_paddr_o,
    output logic                  apb_psel_o,
    output logic                  apb_penable_o,
    input  logic [31:0]           apb_prdata_i,
    input  logic                  apb_pready_i,
    input  logic                  apb_pslverr_i
);
    import sv32_pkg::*;

    // Walker to TLB
    logic [9:0] tlb_vpn1;
    logic [9:0] tlb_vpn0;
    logic       tlb_hit;
    pte_t       tlb_pte;
    logic       tlb_mega;
    logic       fill_en;
    vaddr_u     fill_vaddr;
    pte_t       fill_pte;
    logic       fill_mega;
    logic       tlb_flush;

    ptw u_ptw (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid_i   (req_valid_i),
        .req_ready_o   (req_ready_o),
        .req_vaddr_i   (req_vaddr_i),
        .req_acc_i     (req_acc_i),
        .satp_ppn_i    (satp_ppn_i),
        .mxr_i         (mxr_i),
        .flush_i       (flush_i),
        .rsp_valid_o   (rsp_valid_o),
        .rsp_paddr_o   (rsp_paddr_o),
        .rsp_fault_o   (rsp_fault_o),
        .apb_paddr_o   (apb_paddr_o),
        .apb_psel_o    (apb_psel_o),
        .apb_penable_o (apb_penable_o),
        .apb_prdata_i  (apb_prdata_i),
        .apb_pready_i  (apb_pready_i),
        .apb_pslverr_i (apb_pslverr_i),
        .tlb_vpn1_o    (tlb_vpn1),
        .tlb_vpn0_o    (tlb_vpn0),
        .tlb_hit_i     (tlb_hit),
        .tlb_pte_i     (tlb_pte),
        .tlb_mega_i    (tlb_mega),
        .fill_en_o     (fill_en),
        .fill_vaddr_o  (fill_vaddr),
        .fill_pte_o    (fill_pte),
        .fill_mega_o   (fill_mega),
        .flush_o       (tlb_flush)
    );

    tlb u_tlb (
        .clk          (clk),
        .rst_n        (rst_n),
        .lk_vpn1_i    (tlb_vpn1),
        .lk_vpn0_i    (tlb_vpn0),
        .hit_o        (tlb_hit),
        .hit_pte_o    (tlb_pte),
        .hit_mega_o   (tlb_mega),
        .fill_en_i    (fill_en),
        .fill_vaddr_i (fill_vaddr),
        .fill_pte_i   (fill_pte),
        .fill_mega_i  (fill_mega),
        .flush_i      (tlb_flush)
    );

endmodule

/* logic/ptw.sv */
`timescale 1ns/1ps
`include "mmu_config.svh"

module ptw (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      req_valid_i,
    output logic                      req_ready_o,
    input  logic [`MMU_VALEN-1:0]     req_vaddr_i,
    input  sv32_pkg::access_e         req_acc_i,
    input  logic [`MMU_PPN_W-1:0]     satp_ppn_i,
    input  logic                      mxr_i,
    input  logic                      flush_i,
    output logic                      rsp_valid_o,
    output logic [`MMU_PALEN-1:0]     rsp_paddr_o,
    output mmu_ctrl_pkg::fault_e      rsp_fault_o,
    output logic [`MMU_PALEN-1:0]     apb_paddr_o,
    output logic                      apb_psel_o,
    output logic                      apb_penable_o,
    input  logic [31:0]               apb_prdata_i,
    input  logic                      apb_pready_i,
    input  logic                      apb_pslverr_i,
    output logic [9:0]                tlb_vpn1_o,
    output logic [9:0]                tlb_vpn0_o,
    input  logic                      tlb_hit_i,
    input  sv32_pkg::pte_t            tlb_pte_i,
    input  logic                      tlb_mega_i,
    output logic                      fill_en_o,
    output sv32_pkg::vaddr_u          fill_vaddr_o,
    output sv32_pkg::pte_t            fill_pte_o,
    output logic                      fill_mega_o,
    output logic                      flush_o
);
    import sv32_pkg::*;
    import mmu_ctrl_pkg::*;

    ptw_state_e            state_q, state_d;
    walk_level_e           level_q, level_d;
    fault_e                fault_q, fault_d;
    logic                  fill_q, fill_d;

    vaddr_u                req_va;
    vaddr_u                vaddr_q;
    access_e               acc_q;
    logic                  mxr_q;
    logic [`MMU_PALEN-1:0] addr_q;
    pte_t                  pte_q;
    logic                  err_q;
    logic [`MMU_PALEN-1:0] paddr_q;
    logic [`MMU_PALEN-1:0] leaf_paddr;

    logic                  chk_leaf;
    fault_e                chk_fault;

    pte_check u_pte_check (
        .pte_i     (pte_q),
        .acc_i     (acc_q),
        .mxr_i     (mxr_q),
        .level_i   (level_q),
        .is_leaf_o (chk_leaf),
        .fault_o   (chk_fault)
    );

    // TLB is looked up straight from the incoming request
    assign req_va     = req_vaddr_i;
    assign tlb_vpn1_o = req_va.page_4k.vpn1;
    assign tlb_vpn0_o = req_va.page_4k.vpn0;

    // Offset width depends on the level the leaf came from
    assign leaf_paddr = (level_q == LEVEL_1) ?
                        {pte_q.ppn1, vaddr_q.page_4m.off22} :
                        {pte_q.ppn1, pte_q.ppn0, vaddr_q.page_4k.off12};

    always_comb begin
        state_d = state_q;
        level_d = level_q;
        fault_d = fault_q;
        fill_d  = fill_q;
        case (state_q)
            PTW_IDLE: begin
                if (req_valid_i) begin
                    fault_d = FAULT_NONE;
                    fill_d  = 1'b0;
                    if (tlb_hit_i) begin
                        state_d = PTW_HIT;
                        level_d = tlb_mega_i ? LEVEL_1 : LEVEL_2;
                    end else begin
                        state_d = PTW_SETUP;
                        level_d = LEVEL_1;
                    end
                end
            end
            PTW_SETUP:  state_d = PTW_ACCESS;
            PTW_ACCESS: begin
                if (apb_pready_i) begin
                    state_d = PTW_CHECK;
                end
            end
            PTW_HIT, PTW_CHECK: begin
                state_d = PTW_DONE;
                if (err_q) begin
                    fault_d = FAULT_ACCESS;
                end else if (chk_fault != FAULT_NONE) begin
                    fault_d = chk_fault;
                end else if (chk_leaf) begin
                    // Cached translations are not written back
                    fill_d = (state_q == PTW_CHECK);
                end else begin
                    state_d = PTW_SETUP;
                    level_d = LEVEL_2;
                end
            end
            PTW_DONE: state_d = PTW_IDLE;
            default:  state_d = PTW_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= PTW_IDLE;
            level_q <= LEVEL_1;
            fault_q <= FAULT_NONE;
            fill_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            level_q <= level_d;
            fault_q <= fault_d;
            fill_q  <= fill_d;
        end
    end

    always_ff @(posedge clk) begin
        case (state_q)
            PTW_IDLE: begin
                if (req_valid_i) begin
                    vaddr_q <= req_va;
                    acc_q   <= req_acc_i;
                    mxr_q   <= mxr_i;
                    pte_q   <= tlb_pte_i;
                    err_q   <= 1'b0;
                    addr_q  <= {satp_ppn_i, req_va.page_4k.vpn1, 2'b00};
                end
            end
            PTW_ACCESS: begin
                if (apb_pready_i) begin
                    pte_q <= pte_t'(apb_prdata_i);
                    err_q <= apb_pslverr_i;
                end
            end
            PTW_HIT, PTW_CHECK: begin
                // Next-level address, only used when the PTE is a pointer
                addr_q  <= {pte_q.ppn1, pte_q.ppn0, vaddr_q.page_4k.vpn0, 2'b00};
                paddr_q <= (state_d == PTW_DONE && fault_d == FAULT_NONE) ? leaf_paddr : '0;
            end
            default: ;
        endcase
    end

    assign req_ready_o   = (state_q == PTW_IDLE);

    // APB read, setup for one cycle then access until pready
    assign apb_paddr_o   = addr_q;
    assign apb_psel_o    = (state_q == PTW_SETUP) || (state_q == PTW_ACCESS);
    assign apb_penable_o = (state_q == PTW_ACCESS);

    assign rsp_valid_o   = (state_q == PTW_DONE);
    assign rsp_paddr_o   = paddr_q;
    assign rsp_fault_o   = fault_q;

    // Fill goes out with the response
    assign fill_en_o     = (state_q == PTW_DONE) && fill_q;
    assign fill_vaddr_o  = vaddr_q;
    assign fill_pte_o    = pte_q;
    assign fill_mega_o   = (level_q == LEVEL_1);
    assign flush_o       = flush_i;

endmodule

/* logic/tlb.sv */
`timescale 1ns/1ps
`include "mmu_config.svh"

module tlb (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [9:0]       lk_vpn1_i,
    input  logic [9:0]       lk_vpn0_i,
    output logic             hit_o,
    output sv32_pkg::pte_t   hit_pte_o,
    output logic             hit_mega_o,
    input  logic             fill_en_i,
    input  sv32_pkg::vaddr_u fill_vaddr_i,
    input  sv32_pkg::pte_t   fill_pte_i,
    input  logic             fill_mega_i,
    input  logic             flush_i
);
    import sv32_pkg::*;

    localparam int N     = `MMU_TLB_ENTRIES;
    localparam int IDX_W = $clog2(N);

    logic [N-1:0]     valid_q;
    logic [9:0]       vpn1_q [N];
    logic [9:0]       vpn0_q [N];
    pte_t             pte_q  [N];
    logic [N-1:0]     mega_q;
    logic [IDX_W-1:0] rr_q;
    logic [N-1:0]     match;

    // Megapage entries ignore VPN0
    always_comb begin
        for (int i = 0; i < N; i++) begin
            match[i] = valid_q[i] && (vpn1_q[i] == lk_vpn1_i) &&
                       (mega_q[i] || (vpn0_q[i] == lk_vpn0_i));
        end
    end

    // Lowest matching entry wins
    always_comb begin
        hit_o      = 1'b0;
        hit_pte_o  = '0;
        hit_mega_o = 1'b0;
        for (int i = N - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_o      = 1'b1;
                hit_pte_o  = pte_q[i];
                hit_mega_o = mega_q[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            rr_q    <= '0;
        end else begin
            if (flush_i) begin
                valid_q <= '0;
            end
            // A fill in the flush cycle still lands
            if (fill_en_i) begin
                valid_q[rr_q] <= 1'b1;
                rr_q          <= (rr_q == IDX_W'(N - 1)) ? '0 : rr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en_i) begin
            vpn1_q[rr_q] <= fill_vaddr_i.page_4k.vpn1;
            vpn0_q[rr_q] <= fill_vaddr_i.page_4k.vpn0;
            pte_q[rr_q]  <= fill_pte_i;
            mega_q[rr_q] <= fill_mega_i;
        end
    end

endmodule

/* logic/pte_check.sv */
`timescale 1ns/1ps

module pte_check (
    input  sv32_pkg::pte_t            pte_i,
    input  sv32_pkg::access_e         acc_i,
    input  logic                      mxr_i,
    input  mmu_ctrl_pkg::walk_level_e level_i,
    output logic                      is_leaf_o,
    output mmu_ctrl_pkg::fault_e      fault_o
);
    import sv32_pkg::*;
    import mmu_ctrl_pkg::*;

    logic perm_ok;
    logic malformed;
    logic misaligned;

    // Any of r or x marks a leaf, otherwise the PTE points to the next table
    assign is_leaf_o = pte_i.r | pte_i.x;

    // Invalid entry or the reserved w-without-r encoding
    assign malformed = !pte_i.v || (pte_i.w && !pte_i.r);

    // Megapage must be aligned to 4 MiB
    assign misaligned = (level_i == LEVEL_1) && (pte_i.ppn0 != '0);

    // Permission for the requested access kind
    always_comb begin
        case (acc_i)
            ACC_FETCH: perm_ok = pte_i.x;
            // MXR lets loads read execute-only pages
            ACC_LOAD:  perm_ok = pte_i.r | (pte_i.x & mxr_i);
            // No hardware D update, so a clean page faults on store
            ACC_STORE: perm_ok = pte_i.w & pte_i.d;
            default:   perm_ok = 1'b0;
        endcase
    end

    always_comb begin
        fault_o = FAULT_NONE;
        if (malformed) begin
            fault_o = FAULT_PAGE;
        end else if (is_leaf_o) begin
            // A bit is not set by hardware either
            if (!pte_i.a || !perm_ok || misaligned) begin
                fault_o = FAULT_PAGE;
            end
        end else if (level_i == LEVEL_2) begin
            // Pointer at the last level, no leaf to be found
            fault_o = FAULT_PAGE;
        end
    end

endmodule

/* logic/mmu_ctrl_pkg.sv */
package mmu_ctrl_pkg;

    // Walker FSM states
    typedef enum logic [2:0] {
        PTW_IDLE   = 3'd0,
        PTW_HIT    = 3'd1,
        PTW_SETUP  = 3'd2,
        PTW_ACCESS = 3'd3,
        PTW_CHECK  = 3'd4,
        PTW_DONE   = 3'd5
    } ptw_state_e;

    // LEVEL_1 is the root table, a leaf there is a megapage
    typedef enum logic {
        LEVEL_1 = 1'b0,
        LEVEL_2 = 1'b1
    } walk_level_e;

    // Translation result
    typedef enum logic [1:0] {
        FAULT_NONE   = 2'd0,
        FAULT_PAGE   = 2'd1,
        FAULT_ACCESS = 2'd2
    } fault_e;

endpackage

/* logic/sv32_pkg.sv */
package sv32_pkg;

    // Sv32 page table entry, one 32-bit word
    typedef struct packed {
        logic [11:0] ppn1;
        logic [9:0]  ppn0;
        logic [1:0]  rsw;
        logic        d;
        logic        a;
        logic        g;
        logic        u;
        logic        x;
        logic        w;
        logic        r;
        logic        v;
    } pte_t;

    // Virtual address seen as a 4 KiB page
    typedef struct packed {
        logic [9:0]  vpn1;
        logic [9:0]  vpn0;
        logic [11:0] off12;
    } vaddr_4k_t;

    // Virtual address seen as a 4 MiB megapage
    typedef struct packed {
        logic [9:0]  vpn1;
        logic [21:0] off22;
    } vaddr_4m_t;

    // Same word, decoded by the level the leaf was found at
    typedef union packed {
        vaddr_4k_t page_4k;
        vaddr_4m_t page_4m;
    } vaddr_u;

    // Kind of access being translated
    typedef enum logic [1:0] {
        ACC_FETCH = 2'd0,
        ACC_LOAD  = 2'd1,
        ACC_STORE = 2'd2
    } access_e;

endpackage

/* logic/mmu_config.svh */
`ifndef MMU_CONFIG_SVH
`define MMU_CONFIG_SVH

// Sv32 virtual address width
`define MMU_VALEN 32

// Sv32 physical address width, 34 bits from a 22-bit PPN and a 12-bit offset
`define MMU_PALEN 34

// Physical page number width
`define MMU_PPN_W 22

// Number of TLB entries, 2, 4 or 8
`define MMU_TLB_ENTRIES 4

`endif
